/* compile.f */
+incdir+sim
verilog/synth_pkg.sv
verilog/cfg_write_if.sv
verilog/cfg_host_port.sv
verilog/cfg_store.sv
verilog/frame_timer.sv
verilog/phase_counter.sv
verilog/saw_bank.sv
verilog/sweep_unit.sv
verilog/wave_synth_top.sv
sim/synth_tb.sv

/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f compile.f --top-module synth_tb -o synth_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed"
	exit $status
fi

./obj_dir/synth_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation failed"
	exit $status
fi

/* sim/synth_model.svh */
// Cycle level model of the register file, frame, oscillators and sweeps
cfg_array_t m_cfg;
int m_slot;
logic [DIVIDER_BITS-1:0] m_div;
osc_period_t m_saw_count [NUM_OSCS];
sweep_period_t m_sweep_count [NUM_OSCS];
wave_t m_saw [NUM_OSCS];
logic [1:0] m_sync;                 // Bit 1 is the synchronized strobe
logic m_prev;
int m_host_writes;
int m_collisions;                   // Host writes held off by a sweep write

task automatic model_reset();
	m_cfg = '1;
	m_slot = 0;
	m_div = '0;
	m_sync = '0;
	m_prev = 1'b0;
	m_host_writes = 0;
	m_collisions = 0;
	for (int i = 0; i < NUM_OSCS; i++) begin
		m_saw_count[i] = '0;
		m_sweep_count[i] = '0;
		m_saw[i] = '0;
	end
endtask

// Octave k runs on every rising edge of divider bit k-1
function automatic logic octave_enable(input int k);
	logic [DIVIDER_BITS-1:0] next_div;
	next_div = m_div + 1'b1;
	if (k == 0)
		return 1'b1;
	return next_div[k-1] & ~m_div[k-1];
endfunction

task automatic model_step(input logic strobe, input logic [CFG_ADDR_BITS:0] addr,
		input logic [7:0] data);
	cfg_word_t w;
	cfg_word_t sweep_word;
	logic [7:0] sb;
	pitch_t pitch;
	logic sweep_wr;
	logic issue;
	int i;
	sweep_wr = 1'b0;
	i = m_slot;
	if (m_slot < NUM_OSCS) begin
		w = m_cfg[i];
		if (w[12:9] != 4'hf && octave_enable(int'(w[12:9]))) begin
			if (m_saw_count[i] < osc_period_t'(4)) begin
				m_saw_count[i] = m_saw_count[i] + {1'b1, w[8:0]};
				m_saw[i] = m_saw[i] + 1'b1;
			end
			m_saw_count[i] = m_saw_count[i] - osc_period_t'(4);
		end
		sb = m_cfg[2][8*i +: 8];    // Byte 4+i
		if (sb[6:3] != 4'hf && octave_enable(int'(sb[6:3]) + LOG2_SWEEP_UPDATE_PERIOD)) begin
			if (m_sweep_count[i] == '0) begin
				m_sweep_count[i] = m_sweep_count[i] + {1'b1, sb[2:0]};
				pitch = w[12:0];
				sweep_wr = sb[7] ? (pitch != '0) : (pitch != '1);
				sweep_word = {3'b000, sb[7] ? pitch - 1'b1 : pitch + 1'b1};
			end
			m_sweep_count[i] = m_sweep_count[i] - 1'b1;
		end
	end
	// Host edge detect, memory held while a sweep write owns the bus
	issue = m_sync[1] & ~m_prev;
	if (!sweep_wr)
		m_prev = m_sync[1];
	m_sync = {m_sync[0], strobe};
	if (sweep_wr) begin
		m_cfg[i] = sweep_word;
		if (issue)
			m_collisions++;
	end else if (issue) begin
		m_cfg[addr[CFG_ADDR_BITS:1]][8*addr[0] +: 8] = data;
		m_host_writes++;
	end
	if (m_slot == (1 << SLOT_BITS) - 1)
		m_div = m_div + 1'b1;
	m_slot = (m_slot + 1) % (1 << SLOT_BITS);
endtask

/* sim/synth_tb.sv */
`timescale 1ns/1ps

module synth_tb import synth_pkg::*; ();
	logic clk;
	logic reset;
	logic [7:0] cfg_data;
	logic [CFG_ADDR_BITS:0] cfg_addr;
	logic cfg_strobe;
	logic [NUM_OSCS*WAVE_BITS-1:0] wave_out;
	logic [31:0] lfsr;
	cfg_word_t word3;                   // Expected content of the spare word

	`include "synth_model.svh"

	wave_synth_top dut0 (
		.clk(clk),
		.reset(reset),
		.cfg_data(cfg_data),
		.cfg_addr(cfg_addr),
		.cfg_strobe(cfg_strobe),
		.wave_out(wave_out)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// ==========================================================================
	// Random numbers, failure reporting and compares
	// ==========================================================================
	function automatic logic [31:0] lfsr_step(input logic [31:0] state);
		return state[0] ? (state >> 1) ^ 32'h8020_0003 : state >> 1;
	endfunction

	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] value;
		value = '0;
		for (int b = 0; b < n; b++) begin
			lfsr = lfsr_step(lfsr);
			value = {value[30:0], lfsr[0]};
		end
		return value;
	endfunction

	task automatic stop_on_failure(input string reason);
		$display("%s", reason);
		$display("=== FAIL ===");
		$fatal(1, "Simulation stopped");
	endtask

	task automatic check_wave(input wave_t got, input wave_t expected, input int osc);
		if (got !== expected)
			stop_on_failure($sformatf("** Error at %0t: saw %0d is %h, expected %h",
				$time, osc, got, expected));
	endtask

	task automatic check_cfg(input cfg_word_t got, input cfg_word_t expected, input int word);
		if (got !== expected)
			stop_on_failure($sformatf("** Error at %0t: config word %0d is %h, expected %h",
				$time, word, got, expected));
	endtask

	// Model steps on the edge, compares run mid cycle
	always @(posedge clk) begin
		if (reset)
			model_reset();
		else
			model_step(cfg_strobe, cfg_addr, cfg_data);
	end

	always @(negedge clk) begin
		if (reset === 1'b0) begin
			for (int i = 0; i < NUM_OSCS; i++)
				check_wave(wave_out[i*WAVE_BITS +: WAVE_BITS], m_saw[i], i);
			for (int i = 0; i < CFG_WORDS; i++)
				check_cfg(dut0.store.cfg[i], m_cfg[i], i);
		end
	end

	// ==========================================================================
	// Host write tasks
	// ==========================================================================
	// Raise the strobe and hold it until the byte lands, slot -1 means untimed
	task automatic start_write(input logic [CFG_ADDR_BITS:0] addr, input logic [7:0] data,
			input int issue_slot);
		int start;
		int waited;
		start = m_host_writes;
		waited = 0;
		// Strobe needs three edges to reach the edge detect
		while (issue_slot >= 0 && m_slot != (issue_slot + 29) % 32) begin
			@(negedge clk);
			waited++;
			if (waited > 40)
				stop_on_failure("Timeout waiting for the frame slot of a timed host write");
		end
		@(posedge clk);
		cfg_addr <= addr;
		cfg_data <= data;
		cfg_strobe <= 1'b1;
		waited = 0;
		do begin
			@(negedge clk);
			waited++;
			if (waited > 20)
				stop_on_failure("Timeout: host write never reached the register file");
		end while (m_host_writes == start);
		if (addr[CFG_ADDR_BITS:1] == 2'd3) begin
			word3[8*addr[0] +: 8] = data;
			check_cfg(dut0.store.cfg[3], word3, 3);
		end
	endtask

	task automatic end_write();
		int waited;
		@(posedge clk);
		cfg_strobe <= 1'b0;
		waited = 0;
		do begin
			@(negedge clk);
			waited++;
			if (waited > 20)
				stop_on_failure("Timeout: host port did not return to idle");
		end while (m_sync != 2'b00 || m_prev);
	endtask

	task automatic write_byte(input logic [CFG_ADDR_BITS:0] addr, input logic [7:0] data,
			input int issue_slot);
		start_write(addr, data, issue_slot);
		end_write();
	endtask

	// ==========================================================================
	// Test sequence
	// ==========================================================================
	initial begin
		logic [7:0] high_byte;
		logic [7:0] first_byte;
		int waited;
		reset = 1'b1;
		cfg_strobe = 1'b0;
		cfg_addr = '0;
		cfg_data = '0;
		lfsr = 32'h1cc1_617e;
		word3 = '1;
		repeat (4) @(posedge clk);
		reset <= 1'b0;

		// Everything disabled after reset
		repeat (2000) begin
			@(negedge clk);
			for (int i = 0; i < NUM_OSCS; i++)
				check_wave(wave_out[i*WAVE_BITS +: WAVE_BITS], wave_t'(0), i);
		end

		// Random periods, octaves 0 to 6, sweeps still off
		for (int round = 0; round < 3; round++) begin
			for (int i = 0; i < NUM_OSCS; i++) begin
				high_byte = 8'(random_bits(8));
				high_byte[4:1] = 4'(random_bits(3) % 7);
				write_byte({2'(i), 1'b0}, 8'(random_bits(8)), -1);
				write_byte({2'(i), 1'b1}, high_byte, -1);
			end
			repeat (20000) @(posedge clk);
		end

		// A long strobe with changing data writes one byte only
		first_byte = 8'(random_bits(8));
		start_write(3'b110, first_byte, -1);
		repeat (40) begin
			@(posedge clk);
			cfg_data <= 8'(random_bits(8));
		end
		end_write();
		check_cfg(dut0.store.cfg[3], word3, 3);

		// Oscillator 0 sweeps down from pitch 5, oscillator 1 up from 8186
		write_byte(3'b000, 8'h05, -1);
		write_byte(3'b001, 8'h00, -1);
		write_byte(3'b010, 8'hfa, -1);
		write_byte(3'b011, 8'h1f, -1);
		write_byte(3'b100, {1'b1, 4'd0, 3'(random_bits(3))}, -1);
		write_byte(3'b101, {1'b0, 4'd0, 3'(random_bits(3))}, -1);
		waited = 0;
		do begin
			@(negedge clk);
			waited++;
			if (waited > 40000)
				stop_on_failure("Timeout: sweeps never reached the ends of the pitch range");
		end while (m_cfg[0][12:0] != '0 || m_cfg[1][12:0] != '1);
		repeat (8000) @(posedge clk);
		@(negedge clk);
		check_cfg(dut0.store.cfg[0], 16'h0000, 0);
		check_cfg(dut0.store.cfg[1], 16'h1fff, 1);

		// Mid range pitches keep both sweeps writing, host writes aimed at slots 0 and 1
		write_byte(3'b001, 8'h08, -1);
		write_byte(3'b011, 8'h08, -1);
		write_byte(3'b100, 8'h80, -1);
		write_byte(3'b101, 8'h00, -1);
		for (int n = 0; n < 256; n++)
			write_byte({2'd3, 1'(random_bits(1))}, 8'(random_bits(8)), int'(random_bits(1)));
		if (m_collisions == 0)
			stop_on_failure("No host write collided with a sweep write");

		$display("=== PASS ===");
		$finish;
	end
endmodule

/* verilog/cfg_host_port.sv */
`timescale 1ns/1ps

module cfg_host_port import synth_pkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic [7:0] cfg_data,
	input  logic [CFG_ADDR_BITS:0] cfg_addr,   // Word in upper bits, byte select in bit 0
	input  logic cfg_strobe,
	cfg_write_if.initiator wr
);
	logic [1:0] strobe_sync;
	logic strobe;
	logic prev_strobe;
	logic strobed;

	assign strobe = strobe_sync[0];

	// Two stage synchronizer, edge memory held while the port is locked out
	always_ff @(posedge clk) begin
		if (reset) begin
			strobe_sync <= '0;
			prev_strobe <= 1'b0;
		end else begin
			strobe_sync <= {cfg_strobe, strobe_sync[1]};
			if (wr.granted)
				prev_strobe <= strobe;   // Denied edge is retried next cycle
		end
	end

	assign strobed = strobe & ~prev_strobe;

	// Byte write, same byte on both halves
	assign wr.we = {strobed & cfg_addr[0], strobed & ~cfg_addr[0]};
	assign wr.addr = cfg_addr[CFG_ADDR_BITS:1];
	assign wr.data = {cfg_data, cfg_data};
endmodule

/* verilog/cfg_store.sv */
`timescale 1ns/1ps

module cfg_store import synth_pkg::*; (
	input  logic clk,
	input  logic reset,
	cfg_write_if.target host,
	cfg_write_if.target sweep,
	output cfg_array_t cfg
);
	logic sweep_active;
	byte_en_t we;
	cfg_addr_t addr;
	cfg_word_t data;

	// ==========================================================================
	// Fixed priority arbiter, sweep side first
	// ==========================================================================
	assign sweep_active = |sweep.we;
	assign host.granted = ~sweep_active;
	assign sweep.granted = 1'b1;

	assign we = sweep_active ? sweep.we : host.we;
	assign addr = sweep_active ? sweep.addr : host.addr;
	assign data = sweep_active ? sweep.data : host.data;

	// ==========================================================================
	// Register file
	// ==========================================================================
	always_ff @(posedge clk) begin
		if (reset) begin
			cfg <= '1;   // All ones keeps every counter disabled
		end else begin
			for (int i = 0; i < CFG_WORDS; i++) begin
				if (addr == cfg_addr_t'(i)) begin
					for (int b = 0; b < $bits(byte_en_t); b++) begin
						if (we[b])
							cfg[i][8*b +: 8] <= data[8*b +: 8];
					end
				end
			end
		end
	end
endmodule

/* verilog/cfg_write_if.sv */
`timescale 1ns/1ps

// One write port into the configuration register file
interface cfg_write_if import synth_pkg::*; ();
	byte_en_t we;       // Byte enables, no write when zero
	cfg_addr_t addr;
	cfg_word_t data;
	logic granted;      // Port may write this cycle

	modport initiator (
		output we,
		output addr,
		output data,
		input  granted
	);

	modport target (
		input  we,
		input  addr,
		input  data,
		output granted
	);
endinterface

/* verilog/frame_timer.sv */
`timescale 1ns/1ps

module frame_timer import synth_pkg::*; (
	input  logic clk,
	input  logic reset,
	output logic slot_valid,
	output osc_index_t osc_index,
	output oct_enables_t oct_enables
);
	slot_t slot;
	logic [SLOT_BITS:0] next_slot;
	logic frame_end;
	logic [DIVIDER_BITS-1:0] divider;
	logic [DIVIDER_BITS-1:0] next_divider;

	assign next_slot = {1'b0, slot} + 1'b1;
	assign frame_end = next_slot[SLOT_BITS];   // Slot 31
	assign next_divider = divider + 1'b1;

	always_ff @(posedge clk) begin
		if (reset) begin
			slot <= '0;
			divider <= '0;
		end else begin
			slot <= next_slot[SLOT_BITS-1:0];
			if (frame_end)
				divider <= next_divider;
		end
	end

	// One pulse per rising bit of the divider, octave 0 runs every frame
	assign oct_enables = {next_divider & ~divider, 1'b1};

	assign slot_valid = slot < NUM_OSCS;
	assign osc_index = slot[$bits(osc_index_t)-1:0];
endmodule

/* verilog/phase_counter.sv */
`timescale 1ns/1ps

module phase_counter import synth_pkg::*; #(
	parameter type count_t = logic [3:0],
	parameter int LOG2_STEP = 0
) (
	input  logic clk,
	input  logic reset,
	input  logic enable,
	input  osc_index_t index,
	input  count_t period,
	output logic trigger
);
	count_t count [NUM_OSCS];
	count_t cur;
	count_t next_count;

	assign cur = count[index];
	assign trigger = enable & ((cur >> LOG2_STEP) == '0);   // Next step would wrap
	assign next_count = cur + (trigger ? period : count_t'(0)) - count_t'(1 << LOG2_STEP);

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < NUM_OSCS; i++)
				count[i] <= '0;
		end else if (enable) begin
			count[index] <= next_count;
		end
	end
endmodule

/* verilog/saw_bank.sv */
`timescale 1ns/1ps

module saw_bank import synth_pkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic slot_valid,
	input  osc_index_t osc_index,
	input  oct_enables_t oct_enables,
	input  cfg_array_t cfg,
	output logic [NUM_OSCS*WAVE_BITS-1:0] wave_out
);
	osc_period_t osc_period [NUM_OSCS];
	oct_t osc_oct [NUM_OSCS];
	wave_t saw [NUM_OSCS];
	oct_t cur_oct;
	logic saw_en;
	logic trigger;

	// ==========================================================================
	// Field decode
	// ==========================================================================
	for (genvar i = 0; i < NUM_OSCS; i++) begin : g_decode
		// Mantissa gets its implied leading one
		assign osc_period[i] = {1'b1, cfg[OSC_PERIOD_BASE+i][OSC_PERIOD_BITS-2:0]};
		assign osc_oct[i] = cfg[OSC_PERIOD_BASE+i][OSC_PERIOD_BITS-2+OCT_BITS -: OCT_BITS];
	end

	assign cur_oct = osc_oct[osc_index];
	assign saw_en = oct_enables[cur_oct] & ~&cur_oct;   // Octave 15 means off

	// ==========================================================================
	// Shared phase counter and saw registers
	// ==========================================================================
	phase_counter #(
		.count_t(osc_period_t),
		.LOG2_STEP(WAVE_BITS)
	) saw_counter (
		.clk(clk),
		.reset(reset),
		.enable(slot_valid & saw_en),
		.index(osc_index),
		.period(osc_period[osc_index]),
		.trigger(trigger)
	);

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < NUM_OSCS; i++)
				saw[i] <= '0;
		end else if (trigger) begin
			saw[osc_index] <= saw[osc_index] + 1'b1;
		end
	end

	for (genvar i = 0; i < NUM_OSCS; i++) begin : g_out
		assign wave_out[i*WAVE_BITS +: WAVE_BITS] = saw[i];   // Saw 0 in the low bits
	end
endmodule

/* verilog/sweep_unit.sv */
`timescale 1ns/1ps

module sweep_unit import synth_pkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic slot_valid,
	input  osc_index_t osc_index,
	input  oct_enables_t oct_enables,
	input  cfg_array_t cfg,
	cfg_write_if.initiator wr
);
	logic [7:0] sweep_cfg [NUM_OSCS];
	sweep_period_t sweep_period [NUM_OSCS];
	oct_t sweep_oct [NUM_OSCS];
	logic sweep_down [NUM_OSCS];
	oct_t cur_oct;
	logic [OCT_BITS:0] enable_bit;
	logic sweep_en;
	logic trigger;
	logic cur_down;
	pitch_t cur_pitch;
	pitch_t next_pitch;
	logic at_min;
	logic at_max;
	logic do_sweep;

	// ==========================================================================
	// Sweep byte decode
	// ==========================================================================
	for (genvar i = 0; i < NUM_OSCS; i++) begin : g_decode
		assign sweep_cfg[i] = cfg[(SWEEP_BASE8+i)/2][((SWEEP_BASE8+i)%2)*8 +: 8];
		assign sweep_period[i] = {1'b1, sweep_cfg[i][SWEEP_PERIOD_BITS-2:0]};
		assign sweep_oct[i] = sweep_cfg[i][SWEEP_PERIOD_BITS-2+OCT_BITS -: OCT_BITS];
		assign sweep_down[i] = sweep_cfg[i][7];
	end

	// Enable taken a fixed number of octaves below the oscillators
	assign cur_oct = sweep_oct[osc_index];
	assign enable_bit = {1'b0, cur_oct} + (OCT_BITS+1)'(LOG2_SWEEP_UPDATE_PERIOD);
	assign sweep_en = oct_enables[enable_bit] & ~&cur_oct;

	phase_counter #(
		.count_t(sweep_period_t),
		.LOG2_STEP(0)
	) sweep_counter (
		.clk(clk),
		.reset(reset),
		.enable(slot_valid & sweep_en),
		.index(osc_index),
		.period(sweep_period[osc_index]),
		.trigger(trigger)
	);

	// ==========================================================================
	// Pitch step with clamping
	// ==========================================================================
	assign cur_down = sweep_down[osc_index];
	assign cur_pitch = cfg[OSC_PERIOD_BASE+osc_index][PITCH_BITS-1:0];
	assign next_pitch = cur_down ? cur_pitch - 1'b1 : cur_pitch + 1'b1;
	assign at_min = cur_pitch == '0;
	assign at_max = &cur_pitch;
	assign do_sweep = trigger & (cur_down ? ~at_min : ~at_max);

	// Whole word rewrite, upper bits cleared
	assign wr.we = {$bits(byte_en_t){do_sweep}};
	assign wr.addr = cfg_addr_t'(OSC_PERIOD_BASE + osc_index);
	assign wr.data = cfg_word_t'(next_pitch);
endmodule

/* verilog/synth_pkg.sv */
package synth_pkg;

	// ==========================================================================
	// Widths and counts
	// ==========================================================================
	localparam int OCT_BITS = 4;
	localparam int OSC_PERIOD_BITS = 10;                // Includes the implied leading one
	localparam int PITCH_BITS = OCT_BITS + OSC_PERIOD_BITS - 1;
	localparam int SWEEP_PERIOD_BITS = 4;
	localparam int WAVE_BITS = 2;
	localparam int SLOT_BITS = 5;                       // 32 cycles per sample frame
	localparam int DIVIDER_BITS = 17;
	localparam int LOG2_SWEEP_UPDATE_PERIOD = 2;        // Sweeps run two octaves below pitch
	localparam int NUM_OSCS = 2;
	localparam int CFG_WORDS = 4;
	localparam int CFG_ADDR_BITS = 2;

	// Register file layout
	localparam int OSC_PERIOD_BASE = 0;                 // Word index
	localparam int SWEEP_BASE8 = 4;                     // Byte index

	// ==========================================================================
	// Shared types
	// ==========================================================================
	typedef logic [15:0] cfg_word_t;
	typedef cfg_word_t [CFG_WORDS-1:0] cfg_array_t;
	typedef logic [CFG_ADDR_BITS-1:0] cfg_addr_t;
	typedef logic [1:0] byte_en_t;
	typedef logic [SLOT_BITS-1:0] slot_t;
	typedef logic [$clog2(NUM_OSCS)-1:0] osc_index_t;
	typedef logic [OSC_PERIOD_BITS-1:0] osc_period_t;
	typedef logic [SWEEP_PERIOD_BITS-1:0] sweep_period_t;
	typedef logic [WAVE_BITS-1:0] wave_t;
	typedef logic [OCT_BITS-1:0] oct_t;
	typedef logic [PITCH_BITS-1:0] pitch_t;
	typedef logic [DIVIDER_BITS:0] oct_enables_t;     // Bit 0 is always set

endpackage

/* verilog/wave_synth_top.sv */
`timescale 1ns/1ps

module wave_synth_top import synth_pkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic [7:0] cfg_data,
	input  logic [CFG_ADDR_BITS:0] cfg_addr,
	input  logic cfg_strobe,
	output logic [NUM_OSCS*WAVE_BITS-1:0] wave_out
);
	logic slot_valid;
	osc_index_t osc_index;
	oct_enables_t oct_enables;
	cfg_array_t cfg;

	cfg_write_if host_wr ();
	cfg_write_if sweep_wr ();

	// ==========================================================================
	// Configuration path
	// ==========================================================================
	cfg_host_port host_port (
		.clk(clk),
		.reset(reset),
		.cfg_data(cfg_data),
		.cfg_addr(cfg_addr),
		.cfg_strobe(cfg_strobe),
		.wr(host_wr)
	);

	cfg_store store (
		.clk(clk),
		.reset(reset),
		.host(host_wr),
		.sweep(sweep_wr),
		.cfg(cfg)
	);

	// ==========================================================================
	// Timing, oscillators and sweeps
	// ==========================================================================
	frame_timer timer (
		.clk(clk),
		.reset(reset),
		.slot_valid(slot_valid),
		.osc_index(osc_index),
		.oct_enables(oct_enables)
	);

	saw_bank saws (
		.clk(clk),
		.reset(reset),
		.slot_valid(slot_valid),
		.osc_index(osc_index),
		.oct_enables(oct_enables),
		.cfg(cfg),
		.wave_out(wave_out)
	);

	sweep_unit sweeps (
		.clk(clk),
		.reset(reset),
		.slot_valid(slot_valid),
		.osc_index(osc_index),
		.oct_enables(oct_enables),
		.cfg(cfg),
		.wr(sweep_wr)
	);
endmodule
